//--- flist.f
src/cache_geom_pkg.sv
src/cache_ctrl_pkg.sv
src/cache_tag_array.sv
src/cache_data_array.sv
src/cache_line_xfer.sv
src/cache_ctrl.sv
src/cache_top.sv
tests/cache_assert.sv
tests/cache_tb.sv

//--- src/cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_val,
  input  cache_ctrl_pkg::req_type_t req_type,
  input  cache_geom_pkg::addr_t     req_addr,
  input  cache_geom_pkg::word_t     req_data,
  input  logic                      hit,
  input  cache_geom_pkg::way_t      hit_way,
  input  cache_geom_pkg::way_t      victim_way,
  input  logic                      victim_dirty,
  input  logic                      spill_done,
  input  logic                      refill_done,
  input  cache_geom_pkg::word_t     rd_word,
  output logic                      busy,
  output logic                      resp_val,
  output cache_geom_pkg::word_t     resp_data,
  output cache_geom_pkg::index_t    index,
  output cache_geom_pkg::tag_t      tag,
  output cache_geom_pkg::offset_t   offset,
  output cache_geom_pkg::word_t     req_word,
  output logic                      tag_write,
  output logic                      dirty_set,
  output logic                      lru_touch,
  output cache_geom_pkg::way_t      access_way,
  output logic                      fill_en,
  output logic                      word_en,
  output logic                      spill_go,
  output logic                      refill_go
);

  cache_ctrl_pkg::ctrl_state_t state;
  cache_ctrl_pkg::ctrl_state_t state_next;
  cache_ctrl_pkg::req_type_t   type_q;
  cache_geom_pkg::addr_t       addr_q;
  cache_geom_pkg::word_t       data_q;
  logic accept;
  logic is_write;

  assign accept = req_val && (state == cache_ctrl_pkg::ST_IDLE);

  // Request register
  always_ff @(posedge clk) begin
    if (accept) begin
      type_q <= req_type;
      addr_q <= req_addr;
      data_q <= req_data;
    end
  end

  assign tag      = addr_q[cache_geom_pkg::ADDR_W-1 -: cache_geom_pkg::TAG_W];
  assign index    = addr_q[cache_geom_pkg::BYTE_OFS_W+cache_geom_pkg::OFFSET_W +:
                           cache_geom_pkg::INDEX_W];
  assign offset   = addr_q[cache_geom_pkg::BYTE_OFS_W +: cache_geom_pkg::OFFSET_W];
  assign req_word = data_q;
  assign is_write = (type_q == cache_ctrl_pkg::REQ_WRITE);

  // ----------------------------------------------------------
  // FSM
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_ctrl_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      cache_ctrl_pkg::ST_IDLE: begin
        if (req_val) begin
          state_next = cache_ctrl_pkg::ST_TAG_CHECK;
        end
      end
      cache_ctrl_pkg::ST_TAG_CHECK: begin
        if (hit) begin
          state_next = cache_ctrl_pkg::ST_ACCESS;
        end else if (victim_dirty) begin
          state_next = cache_ctrl_pkg::ST_SPILL;
        end else begin
          state_next = cache_ctrl_pkg::ST_REFILL;
        end
      end
      cache_ctrl_pkg::ST_SPILL: begin
        if (spill_done) begin
          state_next = cache_ctrl_pkg::ST_REFILL;
        end
      end
      cache_ctrl_pkg::ST_REFILL: begin
        if (refill_done) begin
          state_next = cache_ctrl_pkg::ST_FILL;
        end
      end
      cache_ctrl_pkg::ST_FILL:   state_next = cache_ctrl_pkg::ST_ACCESS;
      cache_ctrl_pkg::ST_ACCESS: state_next = cache_ctrl_pkg::ST_IDLE;
      default:                   state_next = cache_ctrl_pkg::ST_IDLE;
    endcase
  end

  // Hit way once resident, victim way while missing
  assign access_way = hit ? hit_way : victim_way;

  assign busy      = (state != cache_ctrl_pkg::ST_IDLE);
  assign resp_val  = (state == cache_ctrl_pkg::ST_ACCESS);
  assign resp_data = (resp_val && !is_write) ? rd_word : '0;

  assign spill_go  = (state == cache_ctrl_pkg::ST_SPILL);
  assign refill_go = (state == cache_ctrl_pkg::ST_REFILL);
  assign fill_en   = (state == cache_ctrl_pkg::ST_FILL);
  assign tag_write = fill_en;
  assign word_en   = resp_val && is_write;
  assign dirty_set = word_en;
  assign lru_touch = resp_val;

endmodule

//--- src/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_type_t;

  // Miss handling walks spill, refill, fill, then access
  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_TAG_CHECK = 3'd1,
    ST_SPILL     = 3'd2,
    ST_REFILL    = 3'd3,
    ST_FILL      = 3'd4,
    ST_ACCESS    = 3'd5
  } ctrl_state_t;

endpackage

//--- src/cache_data_array.sv
`timescale 1ns/100ps

module cache_data_array (
  input  logic                    clk,
  input  logic                    reset,
  input  cache_geom_pkg::index_t  index,
  input  cache_geom_pkg::offset_t offset,
  input  cache_geom_pkg::way_t    way,
  input  logic                    fill_en,
  input  cache_geom_pkg::line_t   fill_line,
  input  logic                    word_en,
  input  cache_geom_pkg::word_t   word_data,
  output cache_geom_pkg::word_t   rd_word,
  output cache_geom_pkg::line_t   rd_line
);

  cache_geom_pkg::line_t lines [2][cache_geom_pkg::NUM_SETS];

  // Whole line on refill, single word on a write access
  always_ff @(posedge clk) begin
    if (!reset) begin
      if (fill_en) begin
        lines[way][index] <= fill_line;
      end else if (word_en) begin
        lines[way][index][offset*cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W] <=
          word_data;
      end
    end
  end

  // Combinational read of the selected way
  assign rd_line = lines[way][index];
  assign rd_word = rd_line[offset*cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W];

endmodule

//--- src/cache_geom_pkg.sv
package cache_geom_pkg;

  // Cache geometry
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int LINE_WORDS = 16;
  localparam int LINE_W     = LINE_WORDS * WORD_W;
  localparam int NUM_SETS   = 32;
  localparam int TAG_W      = 21;
  localparam int INDEX_W    = 5;
  localparam int OFFSET_W   = 4;
  localparam int BYTE_OFS_W = 2;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [LINE_W-1:0]   line_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;

  // Way 0 or way 1
  typedef logic way_t;

endpackage

//--- src/cache_line_xfer.sv
`timescale 1ns/100ps

module cache_line_xfer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   spill_go,
  input  logic                   refill_go,
  input  cache_geom_pkg::index_t index,
  input  cache_geom_pkg::tag_t   tag,
  input  cache_geom_pkg::tag_t   victim_tag,
  input  cache_geom_pkg::line_t  victim_line,
  input  logic                   mem_resp_val,
  input  cache_geom_pkg::word_t  mem_resp_data,
  output logic                   mem_req_val,
  output logic                   mem_req_write,
  output cache_geom_pkg::addr_t  mem_req_addr,
  output cache_geom_pkg::word_t  mem_req_data,
  output logic                   spill_done,
  output logic                   refill_done,
  output cache_geom_pkg::line_t  fill_line
);

  logic [cache_geom_pkg::OFFSET_W:0] spill_cnt;
  logic [cache_geom_pkg::OFFSET_W:0] req_cnt;
  logic [cache_geom_pkg::OFFSET_W:0] resp_cnt;
  cache_geom_pkg::offset_t spill_ofs;
  cache_geom_pkg::offset_t req_ofs;
  cache_geom_pkg::offset_t resp_ofs;
  logic spill_issue;
  logic refill_issue;
  logic resp_take;

  assign spill_ofs = spill_cnt[cache_geom_pkg::OFFSET_W-1:0];
  assign req_ofs   = req_cnt[cache_geom_pkg::OFFSET_W-1:0];
  assign resp_ofs  = resp_cnt[cache_geom_pkg::OFFSET_W-1:0];

  assign spill_done   = (spill_cnt == cache_geom_pkg::LINE_WORDS);
  assign refill_done  = (resp_cnt == cache_geom_pkg::LINE_WORDS);
  assign spill_issue  = spill_go && !spill_done;
  assign refill_issue = refill_go && (req_cnt != cache_geom_pkg::LINE_WORDS);
  assign resp_take    = refill_go && mem_resp_val && !refill_done;

  // ----------------------------------------------------------
  // Memory request port
  // ----------------------------------------------------------
  assign mem_req_val   = spill_issue || refill_issue;
  assign mem_req_write = spill_issue;

  always_comb begin
    if (spill_issue) begin
      mem_req_addr = {victim_tag, index, spill_ofs, {cache_geom_pkg::BYTE_OFS_W{1'b0}}};
      mem_req_data = victim_line[spill_ofs*cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W];
    end else begin
      mem_req_addr = {tag, index, req_ofs, {cache_geom_pkg::BYTE_OFS_W{1'b0}}};
      mem_req_data = '0;
    end
  end

  // ----------------------------------------------------------
  // Counters
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      spill_cnt <= '0;
      req_cnt   <= '0;
      resp_cnt  <= '0;
    end else begin
      if (spill_done) begin
        spill_cnt <= '0;
      end else if (spill_issue) begin
        spill_cnt <= spill_cnt + 1'b1;
      end
      if (refill_done) begin
        req_cnt  <= '0;
        resp_cnt <= '0;
      end else begin
        if (refill_issue) begin
          req_cnt <= req_cnt + 1'b1;
        end
        if (resp_take) begin
          resp_cnt <= resp_cnt + 1'b1;
        end
      end
    end
  end

  // Responses land in order
  always_ff @(posedge clk) begin
    if (resp_take) begin
      fill_line[resp_ofs*cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W] <= mem_resp_data;
    end
  end

endmodule

//--- src/cache_tag_array.sv
`timescale 1ns/100ps

module cache_tag_array (
  input  logic                   clk,
  input  logic                   reset,
  input  cache_geom_pkg::index_t index,
  input  cache_geom_pkg::tag_t   tag,
  input  logic                   tag_write,
  input  cache_geom_pkg::way_t   fill_way,
  input  logic                   dirty_set,
  input  logic                   lru_touch,
  input  cache_geom_pkg::way_t   access_way,
  output logic                   hit,
  output cache_geom_pkg::way_t   hit_way,
  output cache_geom_pkg::way_t   victim_way,
  output logic                   victim_dirty,
  output cache_geom_pkg::tag_t   victim_tag
);

  cache_geom_pkg::tag_t tags [2][cache_geom_pkg::NUM_SETS];
  logic [cache_geom_pkg::NUM_SETS-1:0] valid [2];
  logic [cache_geom_pkg::NUM_SETS-1:0] dirty [2];
  logic [cache_geom_pkg::NUM_SETS-1:0] lru;
  logic match0;
  logic match1;

  // ----------------------------------------------------------
  // Lookup, both ways compared at once
  // ----------------------------------------------------------
  assign match0 = valid[0][index] && (tags[0][index] == tag);
  assign match1 = valid[1][index] && (tags[1][index] == tag);
  assign hit    = match0 || match1;
  assign hit_way = match1;

  // LRU bit names the way to replace
  assign victim_way   = lru[index];
  assign victim_dirty = dirty[victim_way][index];
  assign victim_tag   = tags[victim_way][index];

  // ----------------------------------------------------------
  // State updates
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      valid[0] <= '0;
      valid[1] <= '0;
      dirty[0] <= '0;
      dirty[1] <= '0;
      lru      <= '0;
    end else begin
      if (tag_write) begin
        valid[fill_way][index] <= 1'b1;
        dirty[fill_way][index] <= 1'b0;
      end
      if (dirty_set) begin
        dirty[access_way][index] <= 1'b1;
      end
      if (lru_touch) begin
        lru[index] <= ~access_way;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tag_write) begin
      tags[fill_way][index] <= tag;
    end
  end

endmodule

//--- src/cache_top.sv
`timescale 1ns/100ps

module cache_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_val,
  input  cache_ctrl_pkg::req_type_t req_type,
  input  cache_geom_pkg::addr_t     req_addr,
  input  cache_geom_pkg::word_t     req_data,
  output logic                      busy,
  output logic                      resp_val,
  output cache_geom_pkg::word_t     resp_data,
  output logic                      mem_req_val,
  output logic                      mem_req_write,
  output cache_geom_pkg::addr_t     mem_req_addr,
  output cache_geom_pkg::word_t     mem_req_data,
  input  logic                      mem_resp_val,
  input  cache_geom_pkg::word_t     mem_resp_data
);

  cache_geom_pkg::index_t  index;
  cache_geom_pkg::tag_t    tag;
  cache_geom_pkg::offset_t offset;
  cache_geom_pkg::word_t   req_word;
  cache_geom_pkg::word_t   rd_word;
  cache_geom_pkg::line_t   rd_line;
  cache_geom_pkg::line_t   fill_line;
  cache_geom_pkg::tag_t    victim_tag;
  cache_geom_pkg::way_t    hit_way;
  cache_geom_pkg::way_t    victim_way;
  cache_geom_pkg::way_t    access_way;
  logic hit;
  logic victim_dirty;
  logic tag_write;
  logic dirty_set;
  logic lru_touch;
  logic fill_en;
  logic word_en;
  logic spill_go;
  logic refill_go;
  logic spill_done;
  logic refill_done;

  cache_ctrl i_ctrl (
    .clk, .reset, .req_val, .req_type, .req_addr, .req_data,
    .hit, .hit_way, .victim_way, .victim_dirty, .spill_done, .refill_done, .rd_word,
    .busy, .resp_val, .resp_data, .index, .tag, .offset, .req_word,
    .tag_write, .dirty_set, .lru_touch, .access_way, .fill_en, .word_en,
    .spill_go, .refill_go
  );

  cache_tag_array i_tag_array (
    .clk, .reset, .index, .tag, .tag_write, .fill_way(access_way), .dirty_set,
    .lru_touch, .access_way, .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
  );

  cache_data_array i_data_array (
    .clk, .reset, .index, .offset, .way(access_way), .fill_en, .fill_line,
    .word_en, .word_data(req_word), .rd_word, .rd_line
  );

  cache_line_xfer i_line_xfer (
    .clk, .reset, .spill_go, .refill_go, .index, .tag, .victim_tag,
    .victim_line(rd_line), .mem_resp_val, .mem_resp_data, .mem_req_val,
    .mem_req_write, .mem_req_addr, .mem_req_data, .spill_done, .refill_done, .fill_line
  );

endmodule

//--- tests/cache_assert.sv
`timescale 1ns/100ps

module cache_assert (
  input logic clk,
  input logic reset,
  input logic req_val,
  input logic busy,
  input logic hit,
  input logic resp_val,
  input logic mem_req_val
);

  int err_count = 0;

  // ----------------------------------------------------------
  // Reset and handshake rules
  // ----------------------------------------------------------
  reset_idle: assert property (@(posedge clk)
    reset |=> (!busy && !resp_val && !mem_req_val))
    else begin
      $error("busy, resp_val or mem_req_val high after reset");
      err_count++;
    end

  mem_while_busy: assert property (@(posedge clk) disable iff (reset)
    mem_req_val |-> busy)
    else begin
      $error("mem_req_val raised while the cache is idle");
      err_count++;
    end

  resp_one_cycle: assert property (@(posedge clk) disable iff (reset)
    resp_val |=> !resp_val)
    else begin
      $error("resp_val held longer than one cycle");
      err_count++;
    end

  // Hit answers two cycles after the sampling edge
  hit_latency: assert property (@(posedge clk) disable iff (reset)
    (req_val && !busy) ##1 hit |=> (resp_val && !mem_req_val))
    else begin
      $error("hit response not exactly two cycles after acceptance");
      err_count++;
    end

endmodule

//--- tests/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;

  localparam int CLK_HALF     = 2;
  localparam int WAIT_LIMIT   = 200;
  localparam int SET_IDX      = 9;

  logic                      clk;
  logic                      reset;
  logic                      req_val;
  cache_ctrl_pkg::req_type_t req_type;
  cache_geom_pkg::addr_t     req_addr;
  cache_geom_pkg::word_t     req_data;
  logic                      busy;
  logic                      resp_val;
  cache_geom_pkg::word_t     resp_data;
  logic                      mem_req_val;
  logic                      mem_req_write;
  cache_geom_pkg::addr_t     mem_req_addr;
  cache_geom_pkg::word_t     mem_req_data;
  logic                      mem_resp_val;
  cache_geom_pkg::word_t     mem_resp_data;

  logic [31:0] lfsr;
  int cycle;
  int last_ready;
  cache_geom_pkg::word_t mem_words [cache_geom_pkg::addr_t];
  cache_geom_pkg::word_t ref_words [cache_geom_pkg::addr_t];
  cache_geom_pkg::word_t pend_data [$];
  int                    pend_ready [$];
  cache_geom_pkg::addr_t log_addr [$];
  logic                  log_write [$];
  cache_geom_pkg::word_t log_data [$];

  cache_top i_cache_top (.*);

  bind cache_top cache_assert i_cache_assert (.*);

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic value_error(input string msg);
    fail_run($sformatf("CHECK FAILED at %0t: %s", $time, msg));
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  function automatic cache_geom_pkg::addr_t make_addr(input cache_geom_pkg::tag_t tag,
                                                      input int ofs);
    return {tag, cache_geom_pkg::index_t'(SET_IDX), cache_geom_pkg::offset_t'(ofs), 2'b00};
  endfunction

  // Untouched words read back as their own address inverted
  function automatic cache_geom_pkg::word_t expected_word(input cache_geom_pkg::addr_t addr);
    return ref_words.exists(addr) ? ref_words[addr] : ~addr;
  endfunction

  // ----------------------------------------------------------
  // Memory model
  // ----------------------------------------------------------
  always @(negedge clk) begin
    int lat;
    cycle++;
    if (pend_ready.size() != 0 && pend_ready[0] <= cycle) begin
      mem_resp_val = 1'b1;
      mem_resp_data = pend_data.pop_front();
      void'(pend_ready.pop_front());
    end else begin
      mem_resp_val = 1'b0;
      mem_resp_data = '0;
    end
    if (!reset && mem_req_val) begin
      log_addr.push_back(mem_req_addr);
      log_write.push_back(mem_req_write);
      log_data.push_back(mem_req_data);
      if (mem_req_write) begin
        mem_words[mem_req_addr] = mem_req_data;
      end else begin
        lat = 1 + int'(take_bits(2));
        last_ready = (cycle + lat > last_ready) ? cycle + lat : last_ready + 1;
        pend_ready.push_back(last_ready);
        pend_data.push_back(mem_words.exists(mem_req_addr) ? mem_words[mem_req_addr]
                                                            : ~mem_req_addr);
      end
    end
  end

  always @(negedge clk) begin
    if (i_cache_top.i_cache_assert.err_count != 0) begin
      fail_run("A protocol assertion in cache_assert failed");
    end
  end

  // ----------------------------------------------------------
  // Processor side
  // ----------------------------------------------------------
  task automatic cache_access(input cache_ctrl_pkg::req_type_t kind,
                              input cache_geom_pkg::addr_t addr,
                              input cache_geom_pkg::word_t data,
                              output cache_geom_pkg::word_t rdata);
    int waited;
    waited = 0;
    @(negedge clk);
    while (busy) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) fail_run("Timed out waiting for the cache to go idle");
    end
    log_addr.delete();
    log_write.delete();
    log_data.delete();
    req_val = 1'b1;
    req_type = kind;
    req_addr = addr;
    req_data = data;
    if (kind == cache_ctrl_pkg::REQ_WRITE) ref_words[addr] = data;
    @(negedge clk);
    req_val = 1'b0;
    waited = 0;
    while (!resp_val) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) fail_run("Timed out waiting for resp_val");
    end
    rdata = resp_data;
  endtask

  task automatic read_check(input cache_geom_pkg::addr_t addr);
    cache_geom_pkg::word_t got;
    cache_access(cache_ctrl_pkg::REQ_READ, addr, '0, got);
    assert (got == expected_word(addr))
      else value_error($sformatf("read %h gave %h, expected %h", addr, got, expected_word(addr)));
  endtask

  task automatic write_word(input cache_geom_pkg::addr_t addr, input cache_geom_pkg::word_t d);
    cache_geom_pkg::word_t got;
    cache_access(cache_ctrl_pkg::REQ_WRITE, addr, d, got);
    assert (got == '0) else value_error($sformatf("write response data %h not zero", got));
  endtask

  task automatic check_mem_count(input int n);
    assert (log_addr.size() == n)
      else value_error($sformatf("%0d memory requests, expected %0d", log_addr.size(), n));
  endtask

  // Sixteen ascending requests to one line starting at log entry first
  task automatic check_line(input cache_geom_pkg::addr_t base, input int first,
                            input logic is_write);
    cache_geom_pkg::addr_t a;
    for (int i = 0; i < cache_geom_pkg::LINE_WORDS; i++) begin
      a = base + 4 * i;
      assert (log_write[first+i] == is_write && log_addr[first+i] == a)
        else value_error($sformatf("memory request %0d to %h, expected %h write=%0b",
                                   first + i, log_addr[first+i], a, is_write));
      if (is_write) begin
        assert (log_data[first+i] == expected_word(a))
          else value_error($sformatf("spill of %h carried %h", a, log_data[first+i]));
      end
    end
  endtask

  initial begin
    cache_geom_pkg::addr_t a_base;
    cache_geom_pkg::addr_t b_base;
    cache_geom_pkg::addr_t c_base;
    lfsr = 32'h98b5_8216;
    cycle = 0;
    last_ready = 0;
    reset = 1'b1;
    req_val = 1'b0;
    req_type = cache_ctrl_pkg::REQ_READ;
    req_addr = '0;
    req_data = '0;
    mem_resp_val = 1'b0;
    mem_resp_data = '0;
    a_base = make_addr(21'h0a5c3, 0);
    b_base = make_addr(21'h13b71, 0);
    c_base = make_addr(21'h07e20, 0);
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Clean miss, then hit on the filled line
    read_check(a_base + 20);
    check_mem_count(16);
    check_line(a_base, 0, 1'b0);
    read_check(a_base + 8);
    check_mem_count(0);

    // Write hit and its neighbours
    write_word(a_base + 24, take_bits(32));
    read_check(a_base + 24);
    read_check(a_base + 20);
    read_check(a_base + 28);
    check_mem_count(0);

    // Second line in the same set
    read_check(b_base + 4);
    check_mem_count(16);
    check_line(b_base, 0, 1'b0);
    for (int i = 0; i < 4; i++) begin
      read_check(a_base + 4 * i);
      check_mem_count(0);
      read_check(b_base + 4 * i);
      check_mem_count(0);
    end

    // Dirty victim spills before the refill
    read_check(c_base + 12);
    check_mem_count(32);
    check_line(a_base, 0, 1'b1);
    check_line(c_base, 16, 1'b0);
    read_check(a_base + 24);
    check_mem_count(16);
    check_line(a_base, 0, 1'b0);

    repeat (4) @(negedge clk);
    if (i_cache_top.i_cache_assert.err_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      fail_run("Protocol assertion failures reported by cache_assert");
    end
  end

endmodule
